//--- Bender.yml
package:
  name: bus_axi_master

sources:
  # Package first, then the two blocks and the top level.
  - bus_pkg.sv
  - bus_read_arbiter.sv
  - bus_write_channel.sv
  - bus_axi_master.sv
  - target: simulation
    files:
      - bus_tb.sv

//--- all.f
bus_pkg.sv
bus_read_arbiter.sv
bus_write_channel.sv
bus_axi_master.sv
bus_tb.sv

//--- bus_axi_master.sv
`timescale 1ns/1ps

module bus_axi_master #(
    parameter int XLEN = 32
) (
    input  logic              clock,
    input  logic              arst_n,

    output logic [1:0]        io_master_arburst,
    output logic [2:0]        io_master_arsize,
    output logic [7:0]        io_master_arlen,
    output logic [3:0]        io_master_arid,
    output logic [XLEN-1:0]   io_master_araddr,
    output logic              io_master_arvalid,
    input  logic              io_master_arready,

    input  logic [3:0]        io_master_rid,
    input  logic              io_master_rlast,
    input  logic [XLEN-1:0]   io_master_rdata,
    input  logic [1:0]        io_master_rresp,
    input  logic              io_master_rvalid,
    output logic              io_master_rready,

    output logic [1:0]        io_master_awburst,
    output logic [2:0]        io_master_awsize,
    output logic [7:0]        io_master_awlen,
    output logic [3:0]        io_master_awid,
    output logic [XLEN-1:0]   io_master_awaddr,
    output logic              io_master_awvalid,
    input  logic              io_master_awready,

    output logic              io_master_wlast,
    output logic [XLEN-1:0]   io_master_wdata,
    output logic [XLEN/8-1:0] io_master_wstrb,
    output logic              io_master_wvalid,
    input  logic              io_master_wready,

    input  logic [3:0]        io_master_bid,
    input  logic [1:0]        io_master_bresp,
    input  logic              io_master_bvalid,
    output logic              io_master_bready,

    // Fetch.
    input  logic [XLEN-1:0]   ifu_araddr,
    input  logic              ifu_arvalid,
    input  logic              ifu_lock,
    output logic [XLEN-1:0]   bus_ifu_rdata,
    output logic              bus_ifu_rvalid,

    // Load.
    input  logic [XLEN-1:0]   lsu_araddr,
    input  logic              lsu_arvalid,
    input  logic [7:0]        lsu_rstrb,
    output logic [XLEN-1:0]   bus_lsu_rdata,
    output logic              bus_lsu_rvalid,

    // Store.
    input  logic [XLEN-1:0]   lsu_awaddr,
    input  logic              lsu_awvalid,
    input  logic [XLEN-1:0]   lsu_wdata,
    input  logic [7:0]        lsu_wstrb,
    input  logic              lsu_wvalid,
    output logic              bus_lsu_wready
);

    // Port names match one to one.
    bus_read_arbiter #(.XLEN(XLEN)) u_read_arbiter (.*);

    bus_write_channel #(.XLEN(XLEN)) u_write_channel (.*);

endmodule

//--- bus_patterns.txt
// Columns are kind, address, data or load address, strobe, size, expected, second expected.
// Kind 1 store, 2 load, 3 fetch, 4 fetch plus load with ifu_lock low, 5 the same with it high.
00000003 00000010 00000000 00000000 00000002 C0DE0004 00000000
00000002 00000020 00000000 0000000F 00000002 C0DE0008 00000000
00000001 00000020 DEADBEEF 0000000F 00000002 00000000 00000000
00000002 00000020 00000000 0000000F 00000002 DEADBEEF 00000000
00000001 00000024 000000AB 00000001 00000000 00000000 00000000
00000002 00000024 00000000 0000000F 00000002 C0DE00AB 00000000
00000001 00000028 12345678 00000003 00000001 00000000 00000000
00000002 00000028 00000000 0000000F 00000002 C0DE5678 00000000
00000001 0000002C 99000000 00000008 00000002 00000000 00000000
00000002 0000002C 00000000 0000000F 00000002 99DE000B 00000000
00000002 00000028 00000000 00000001 00000000 C0DE5678 00000000
00000002 0000002C 00000000 00000003 00000001 99DE000B 00000000
00000001 00000040 CAFEF00D 0000000F 00000002 00000000 00000000
00000003 00000040 00000000 00000000 00000002 CAFEF00D 00000000
00000004 00000010 00000020 0000000F 00000002 C0DE0004 DEADBEEF
00000005 00000040 00000024 0000000F 00000002 CAFEF00D C0DE00AB
00000001 000003FC 11223344 0000000C 00000002 00000000 00000000
00000003 000003FC 00000000 00000000 00000002 112200FF 00000000
00000004 000003FC 00000028 00000003 00000001 112200FF C0DE5678
00000005 00000024 00000040 0000000F 00000002 C0DE00AB CAFEF00D
00000001 00000020 00005500 00000002 00000001 00000000 00000000
00000002 00000020 00000000 0000000F 00000002 DEAD55EF 00000000

//--- bus_pkg.sv
package bus_pkg;

    // AXI burst and response codes.
    localparam logic [1:0] burst_incr = 2'b01;
    localparam logic [1:0] resp_okay  = 2'b00;

    // Transaction IDs per requester.
    localparam logic [3:0] id_ifu = 4'h1;
    localparam logic [3:0] id_lsu = 4'h2;

    // Highest set strobe bit picks the size.
    function automatic logic [2:0] strb_to_size(input logic [7:0] strb);
        logic [2:0] size;
        if (strb[7:4] != 4'h0) begin
            size = 3'd3;
        end else if (strb[3:2] != 2'h0) begin
            size = 3'd2;
        end else if (strb[1]) begin
            size = 3'd1;
        end else begin
            size = 3'd0;
        end
        return size;
    endfunction

endpackage

//--- bus_read_arbiter.sv
`timescale 1ns/1ps

module bus_read_arbiter import bus_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clock,
    input  logic            arst_n,

    input  logic [XLEN-1:0] ifu_araddr,
    input  logic            ifu_arvalid,
    input  logic            ifu_lock,
    input  logic [XLEN-1:0] lsu_araddr,
    input  logic            lsu_arvalid,
    input  logic [7:0]      lsu_rstrb,

    output logic [1:0]      io_master_arburst,
    output logic [2:0]      io_master_arsize,
    output logic [7:0]      io_master_arlen,
    output logic [3:0]      io_master_arid,
    output logic [XLEN-1:0] io_master_araddr,
    output logic            io_master_arvalid,
    input  logic            io_master_arready,

    input  logic [3:0]      io_master_rid,
    input  logic            io_master_rlast,
    input  logic [XLEN-1:0] io_master_rdata,
    input  logic [1:0]      io_master_rresp,
    input  logic            io_master_rvalid,
    output logic            io_master_rready,

    output logic [XLEN-1:0] bus_ifu_rdata,
    output logic            bus_ifu_rvalid,
    output logic [XLEN-1:0] bus_lsu_rdata,
    output logic            bus_lsu_rvalid
);
    localparam int FULL_SIZE = $clog2(XLEN / 8);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } state_t;

    state_t          state;
    logic            grant_lsu;
    logic [3:0]      id_q;
    logic [2:0]      size_q;
    logic [XLEN-1:0] addr_q;
    logic            ifu_req;
    logic            lsu_req;
    logic            pick_lsu;
    logic            start;
    logic            r_done;

    // A requester is still high in its pulse cycle, so mask it then.
    assign ifu_req  = ifu_arvalid && !bus_ifu_rvalid;
    assign lsu_req  = lsu_arvalid && !bus_lsu_rvalid;
    assign pick_lsu = lsu_req && !(ifu_req && ifu_lock);
    assign start    = (state == st_idle) && (ifu_req || lsu_req);
    assign r_done   = (state == st_data) && io_master_rvalid;

    assign io_master_arburst = burst_incr;
    assign io_master_arlen   = 8'd0;   // Single beat.
    assign io_master_arsize  = size_q;
    assign io_master_arid    = id_q;
    assign io_master_araddr  = addr_q;
    assign io_master_arvalid = (state == st_addr);
    assign io_master_rready  = (state == st_data);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state          <= st_idle;
            grant_lsu      <= 1'b0;
            bus_ifu_rvalid <= 1'b0;
            bus_lsu_rvalid <= 1'b0;
        end else begin
            bus_ifu_rvalid <= 1'b0;
            bus_lsu_rvalid <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        grant_lsu <= pick_lsu;
                        state     <= st_addr;
                    end
                end
                st_addr: begin
                    if (io_master_arready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (io_master_rvalid) begin
                        bus_ifu_rvalid <= !grant_lsu;
                        bus_lsu_rvalid <= grant_lsu;
                        state          <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            addr_q <= pick_lsu ? lsu_araddr : ifu_araddr;
            id_q   <= pick_lsu ? id_lsu : id_ifu;
            size_q <= pick_lsu ? strb_to_size(lsu_rstrb) : 3'(FULL_SIZE);
        end
        if (r_done) begin
            if (grant_lsu) begin
                bus_lsu_rdata <= io_master_rdata;
            end else begin
                bus_ifu_rdata <= io_master_rdata;
            end
        end
    end

    // Load strobe wider than the bus.
    a_arsize_max: assert property (@(posedge clock) disable iff (!arst_n)
        io_master_arvalid |-> io_master_arsize <= 3'(FULL_SIZE));

    a_ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
        io_master_arvalid && !io_master_arready
            |=> io_master_arvalid && $stable(io_master_araddr));

    // Slave must echo the ID on a single last beat.
    a_rid_echo: assert property (@(posedge clock) disable iff (!arst_n)
        io_master_rvalid && io_master_rready
            |-> io_master_rid == id_q && io_master_rlast);

endmodule

//--- bus_tb.sv
`timescale 1ns/1ps

module bus_tb import bus_pkg::*; ();
    localparam int MAX_OPS = 64;
    localparam int COLS    = 7;

    logic        clock;
    logic        arst_n      = 1'b0;
    logic [31:0] ifu_araddr  = '0;
    logic        ifu_arvalid = 1'b0;
    logic        ifu_lock    = 1'b0;
    logic [31:0] lsu_araddr  = '0;
    logic        lsu_arvalid = 1'b0;
    logic [7:0]  lsu_rstrb   = '0;
    logic [31:0] lsu_awaddr  = '0;
    logic        lsu_awvalid = 1'b0;
    logic [31:0] lsu_wdata   = '0;
    logic [7:0]  lsu_wstrb   = '0;
    logic        lsu_wvalid  = 1'b0;
    logic [31:0] bus_ifu_rdata, bus_lsu_rdata;
    logic        bus_ifu_rvalid, bus_lsu_rvalid, bus_lsu_wready;

    logic [1:0]  io_master_arburst, io_master_awburst;
    logic [2:0]  io_master_arsize, io_master_awsize;
    logic [7:0]  io_master_arlen, io_master_awlen;
    logic [3:0]  io_master_arid, io_master_awid, io_master_wstrb;
    logic [31:0] io_master_araddr, io_master_awaddr, io_master_wdata;
    logic        io_master_arvalid, io_master_awvalid, io_master_wvalid;
    logic        io_master_wlast, io_master_rready, io_master_bready;

    // Slave model side.
    logic        io_master_arready = 1'b0;
    logic        io_master_awready = 1'b0;
    logic        io_master_wready  = 1'b0;
    logic        io_master_rvalid  = 1'b0;
    logic        io_master_bvalid  = 1'b0;
    logic [3:0]  io_master_rid     = '0;
    logic [3:0]  io_master_bid     = '0;
    logic [31:0] io_master_rdata   = '0;
    logic        io_master_rlast   = 1'b1;
    logic [1:0]  io_master_rresp   = resp_okay;
    logic [1:0]  io_master_bresp   = resp_okay;

    logic [31:0] mem [0:255];
    logic [31:0] pat [0:MAX_OPS*COLS-1];
    logic [31:0] rng = 32'd37;
    logic [7:0]  ar_idx, aw_idx;
    logic [3:0]  ar_id_q, aw_id_q, wstrb_q;
    logic [31:0] wdata_q, ar_addr_prev, aw_addr_prev;
    logic [1:0]  ar_dly, r_dly, aw_dly, w_dly, b_dly;
    logic        r_pend, aw_got, w_got, b_pend, ar_wait, aw_wait;
    logic [3:0]  ar_ids [$];
    logic [2:0]  ar_sizes [$];
    logic [2:0]  aw_sizes [$];
    int          n_ops, err_count, check_count;
    int          ifu_pulses, lsu_rpulses, lsu_wpulses;
    int          ifu_expect, lsu_rexpect, lsu_wexpect;

    bus_axi_master #(.XLEN(32)) uut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
        end
        return word;
    endfunction

    function automatic logic [31:0] field(input int op, input int col);
        return pat[op * COLS + col];
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp_val);
        check_count++;
        if (got !== exp_val) begin
            err_count++;
            $display("Error: %s is %h, expected %h at %0t", name, got, exp_val, $time);
        end
    endtask

    // AXI slave with 0 to 3 cycles of random wait per channel.
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 256; i++) mem[i] <= 32'hC0DE_0000 | i;
            io_master_arready <= 1'b0;
            io_master_awready <= 1'b0;
            io_master_wready  <= 1'b0;
            io_master_rvalid  <= 1'b0;
            io_master_bvalid  <= 1'b0;
            {r_pend, aw_got, w_got, b_pend} <= '0;
            {ar_dly, aw_dly, w_dly, b_dly}  <= '0;
        end else begin
            rng = xorshift32(rng);
            if (io_master_arvalid && io_master_arready) begin
                io_master_arready <= 1'b0;
                ar_idx  <= io_master_araddr[9:2];
                ar_id_q <= io_master_arid;
                r_pend  <= 1'b1;
                ar_dly  <= rng[1:0];
                r_dly   <= rng[3:2];
            end else if (io_master_arvalid) begin
                if (ar_dly == 0) io_master_arready <= 1'b1;
                else ar_dly <= ar_dly - 1;
            end
            if (io_master_rvalid && io_master_rready) begin
                io_master_rvalid <= 1'b0;
                r_pend <= 1'b0;
            end else if (r_pend && !io_master_rvalid) begin
                if (r_dly == 0) begin
                    io_master_rvalid <= 1'b1;
                    io_master_rdata  <= mem[ar_idx];
                    io_master_rid    <= ar_id_q;   // Echo.
                end else begin
                    r_dly <= r_dly - 1;
                end
            end
            if (io_master_awvalid && io_master_awready) begin
                io_master_awready <= 1'b0;
                aw_idx  <= io_master_awaddr[9:2];
                aw_id_q <= io_master_awid;
                aw_got  <= 1'b1;
                aw_dly  <= rng[5:4];
            end else if (io_master_awvalid) begin
                if (aw_dly == 0) io_master_awready <= 1'b1;
                else aw_dly <= aw_dly - 1;
            end
            if (io_master_wvalid && io_master_wready) begin
                io_master_wready <= 1'b0;
                wdata_q <= io_master_wdata;
                wstrb_q <= io_master_wstrb;
                w_got   <= 1'b1;
                w_dly   <= rng[7:6];
            end else if (io_master_wvalid) begin
                if (w_dly == 0) io_master_wready <= 1'b1;
                else w_dly <= w_dly - 1;
            end
            if (aw_got && w_got && !b_pend) begin
                mem[aw_idx] <= merge_bytes(mem[aw_idx], wdata_q, wstrb_q);
                b_pend <= 1'b1;
            end
            if (io_master_bvalid && io_master_bready) begin
                io_master_bvalid <= 1'b0;
                {b_pend, aw_got, w_got} <= '0;
                b_dly <= rng[9:8];
            end else if (b_pend && !io_master_bvalid) begin
                if (b_dly == 0) begin
                    io_master_bvalid <= 1'b1;
                    io_master_bid    <= aw_id_q;
                end else begin
                    b_dly <= b_dly - 1;
                end
            end
        end
    end

    // Bus monitor. Addresses must hold while a valid waits.
    always @(posedge clock) begin
        if (arst_n) begin
            if (ar_wait) begin
                compare("io_master_arvalid", io_master_arvalid, 1'b1);
                compare("io_master_araddr", io_master_araddr, ar_addr_prev);
            end
            if (aw_wait) begin
                compare("io_master_awvalid", io_master_awvalid, 1'b1);
                compare("io_master_awaddr", io_master_awaddr, aw_addr_prev);
            end
            if (io_master_arvalid && io_master_arready) begin
                ar_ids.push_back(io_master_arid);
                ar_sizes.push_back(io_master_arsize);
                compare("io_master_arburst", io_master_arburst, 2'b01);   // INCR.
                compare("io_master_arlen", io_master_arlen, 8'd0);
            end
            if (io_master_awvalid && io_master_awready) begin
                aw_sizes.push_back(io_master_awsize);
                compare("io_master_awburst", io_master_awburst, 2'b01);
                compare("io_master_awlen", io_master_awlen, 8'd0);
                compare("io_master_awid", io_master_awid, id_lsu);
            end
            if (io_master_wvalid && io_master_wready) begin
                compare("io_master_wlast", io_master_wlast, 1'b1);
            end
            ifu_pulses  += bus_ifu_rvalid;
            lsu_rpulses += bus_lsu_rvalid;
            lsu_wpulses += bus_lsu_wready;
        end
        ar_wait      <= io_master_arvalid && !io_master_arready;
        aw_wait      <= io_master_awvalid && !io_master_awready;
        ar_addr_prev <= io_master_araddr;
        aw_addr_prev <= io_master_awaddr;
    end

    task automatic pop_ar(input logic [3:0] id_exp, input logic [2:0] size_exp);
        if (ar_ids.size() == 0) begin
            err_count++;
            $display("A read finished without any AR handshake on the bus.");
        end else begin
            compare("io_master_arid", ar_ids.pop_front(), id_exp);
            compare("io_master_arsize", ar_sizes.pop_front(), size_exp);
        end
    endtask

    task automatic check_idle();
        compare("io_master_arvalid", io_master_arvalid, 1'b0);
        compare("io_master_rready", io_master_rready, 1'b0);
        compare("io_master_awvalid", io_master_awvalid, 1'b0);
        compare("io_master_wvalid", io_master_wvalid, 1'b0);
        compare("io_master_bready", io_master_bready, 1'b0);
        compare("bus_ifu_rvalid", bus_ifu_rvalid, 1'b0);
        compare("bus_lsu_rvalid", bus_lsu_rvalid, 1'b0);
        compare("bus_lsu_wready", bus_lsu_wready, 1'b0);
    endtask

    task automatic store_and_wait(input logic [31:0] addr, input logic [31:0] data,
                                  input logic [7:0] strb, input logic [2:0] size);
        @(posedge clock);
        lsu_awaddr  <= addr;
        lsu_wdata   <= data;
        lsu_wstrb   <= strb;
        lsu_awvalid <= 1'b1;
        lsu_wvalid  <= 1'b1;
        do @(posedge clock); while (!bus_lsu_wready);
        lsu_awvalid <= 1'b0;
        lsu_wvalid  <= 1'b0;
        lsu_wexpect++;
        if (aw_sizes.size() == 0) begin
            err_count++;
            $display("A store finished without any AW handshake on the bus.");
        end else begin
            compare("io_master_awsize", aw_sizes.pop_front(), size);
        end
    endtask

    task automatic load_and_wait(input logic [31:0] addr, input logic [7:0] strb,
                                 input logic [2:0] size, input logic [31:0] exp_data);
        @(posedge clock);
        lsu_araddr  <= addr;
        lsu_rstrb   <= strb;
        lsu_arvalid <= 1'b1;
        do @(posedge clock); while (!bus_lsu_rvalid);
        lsu_arvalid <= 1'b0;
        lsu_rexpect++;
        compare("bus_lsu_rdata", bus_lsu_rdata, exp_data);
        pop_ar(id_lsu, size);
    endtask

    task automatic fetch_and_wait(input logic [31:0] addr, input logic [31:0] exp_data);
        @(posedge clock);
        ifu_araddr  <= addr;
        ifu_arvalid <= 1'b1;
        do @(posedge clock); while (!bus_ifu_rvalid);
        ifu_arvalid <= 1'b0;
        ifu_expect++;
        compare("bus_ifu_rdata", bus_ifu_rdata, exp_data);
        pop_ar(id_ifu, 3'd2);
    endtask

    // Fetch and load raised on the same edge.
    task automatic race_fetch_load(input logic [31:0] faddr, input logic [31:0] laddr,
                                   input logic [7:0] strb, input logic [2:0] size,
                                   input logic lock,
                                   input logic [31:0] fexp, input logic [31:0] lexp);
        logic got_f;
        logic got_l;
        got_f = 1'b0;
        got_l = 1'b0;
        @(posedge clock);
        ifu_araddr  <= faddr;
        lsu_araddr  <= laddr;
        lsu_rstrb   <= strb;
        ifu_lock    <= lock;
        ifu_arvalid <= 1'b1;
        lsu_arvalid <= 1'b1;
        while (!(got_f && got_l)) begin
            @(posedge clock);
            if (bus_ifu_rvalid) begin
                ifu_arvalid <= 1'b0;
                got_f = 1'b1;
                compare("bus_ifu_rdata", bus_ifu_rdata, fexp);
            end
            if (bus_lsu_rvalid) begin
                lsu_arvalid <= 1'b0;
                got_l = 1'b1;
                compare("bus_lsu_rdata", bus_lsu_rdata, lexp);
            end
        end
        ifu_expect++;
        lsu_rexpect++;
        if (lock) begin
            pop_ar(id_ifu, 3'd2);
            pop_ar(id_lsu, size);
        end else begin
            pop_ar(id_lsu, size);
            pop_ar(id_ifu, 3'd2);
        end
    endtask

    initial begin
        for (int i = 0; i < MAX_OPS * COLS; i++) pat[i] = '0;
        $readmemh("bus_patterns.txt", pat);
        while (n_ops < MAX_OPS && field(n_ops, 0) != 0) n_ops++;
        repeat (10) @(posedge clock);
        arst_n <= 1'b1;
        repeat (3) begin
            @(posedge clock);
            check_idle();
        end
        if (n_ops == 0) begin
            err_count++;
            $display("The pattern file held no operations.");
        end
        for (int op = 0; op < n_ops; op++) begin
            case (field(op, 0))
                1: store_and_wait(field(op, 1), field(op, 2), field(op, 3), field(op, 4));
                2: load_and_wait(field(op, 1), field(op, 3), field(op, 4), field(op, 5));
                3: fetch_and_wait(field(op, 1), field(op, 5));
                4, 5: race_fetch_load(field(op, 1), field(op, 2), field(op, 3), field(op, 4),
                                      field(op, 0) == 5, field(op, 5), field(op, 6));
                default: begin
                    err_count++;
                    $display("Pattern %0d has an unknown operation kind.", op);
                end
            endcase
        end
        repeat (8) @(posedge clock);   // Catch late extra pulses.
        compare("bus_ifu_rvalid pulse count", ifu_pulses, ifu_expect);
        compare("bus_lsu_rvalid pulse count", lsu_rpulses, lsu_rexpect);
        compare("bus_lsu_wready pulse count", lsu_wpulses, lsu_wexpect);
        compare("unmatched AR handshakes", ar_ids.size(), 0);
        compare("unmatched AW handshakes", aw_sizes.size(), 0);
        $display("Patterns: %0d, checks: %0d, errors: %0d", n_ops, check_count, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // A single transfer takes at most 14 cycles with every wait at its maximum.
    initial begin
        wait (n_ops > 0);
        repeat (10 + 20 * n_ops + 40) @(posedge clock);
        $display("Watchdog expired. A response pulse never arrived within the run time.");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- bus_write_channel.sv
`timescale 1ns/1ps

module bus_write_channel import bus_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic              clock,
    input  logic              arst_n,

    input  logic [XLEN-1:0]   lsu_awaddr,
    input  logic              lsu_awvalid,
    input  logic [XLEN-1:0]   lsu_wdata,
    input  logic [7:0]        lsu_wstrb,
    input  logic              lsu_wvalid,

    output logic [1:0]        io_master_awburst,
    output logic [2:0]        io_master_awsize,
    output logic [7:0]        io_master_awlen,
    output logic [3:0]        io_master_awid,
    output logic [XLEN-1:0]   io_master_awaddr,
    output logic              io_master_awvalid,
    input  logic              io_master_awready,

    output logic              io_master_wlast,
    output logic [XLEN-1:0]   io_master_wdata,
    output logic [XLEN/8-1:0] io_master_wstrb,
    output logic              io_master_wvalid,
    input  logic              io_master_wready,

    input  logic [3:0]        io_master_bid,
    input  logic [1:0]        io_master_bresp,
    input  logic              io_master_bvalid,
    output logic              io_master_bready,

    output logic              bus_lsu_wready
);
    localparam int STRB_W    = XLEN / 8;
    localparam int FULL_SIZE = $clog2(STRB_W);

    typedef enum logic [1:0] {
        st_idle,
        st_xfer,
        st_resp
    } state_t;

    state_t state;
    logic   aw_done;
    logic   w_done;
    logic   aw_hs;
    logic   w_hs;

    assign aw_hs = io_master_awvalid && io_master_awready;
    assign w_hs  = io_master_wvalid && io_master_wready;

    // Requester holds these steady until bus_lsu_wready.
    assign io_master_awburst = burst_incr;
    assign io_master_awlen   = 8'd0;
    assign io_master_awid    = id_lsu;
    assign io_master_awaddr  = lsu_awaddr;
    assign io_master_awsize  = strb_to_size(lsu_wstrb);
    assign io_master_wdata   = lsu_wdata;
    assign io_master_wstrb   = lsu_wstrb[STRB_W-1:0];
    assign io_master_wlast   = 1'b1;

    assign io_master_awvalid = (state == st_xfer) && !aw_done;
    assign io_master_wvalid  = (state == st_xfer) && !w_done;
    assign io_master_bready  = (state == st_resp);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state          <= st_idle;
            aw_done        <= 1'b0;
            w_done         <= 1'b0;
            bus_lsu_wready <= 1'b0;
        end else begin
            bus_lsu_wready <= 1'b0;
            case (state)
                st_idle: begin
                    // The store is still held high in its pulse cycle.
                    if (lsu_awvalid && lsu_wvalid && !bus_lsu_wready) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= st_xfer;
                    end
                end
                st_xfer: begin
                    if (aw_hs) aw_done <= 1'b1;
                    if (w_hs) w_done <= 1'b1;
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    if (io_master_bvalid) begin
                        bus_lsu_wready <= 1'b1;
                        state          <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_awsize_max: assert property (@(posedge clock) disable iff (!arst_n)
        io_master_awvalid |-> io_master_awsize <= 3'(FULL_SIZE));

    a_w_hold: assert property (@(posedge clock) disable iff (!arst_n)
        io_master_wvalid && !io_master_wready
            |=> io_master_wvalid && $stable(io_master_wdata));

    // B must answer the store ID.
    a_bid_echo: assert property (@(posedge clock) disable iff (!arst_n)
        io_master_bvalid && io_master_bready
            |-> io_master_bid == id_lsu);

endmodule
